/* rtl/BranchPkg.sv */
package BranchPkg;
    import TagePkg::*;

    localparam int PC_W = 32;

    // travels with the prediction to the core and comes back with the outcome
    typedef struct packed {
        logic [IDX_W-1:0]             baseIdx;
        TableProbe_t [NUM_TAGGED-1:0] probe;
        logic [1:0]                   provider;  // 0 is the base table, t+1 is tagged table t
        logic                         altTaken;
        logic                         predTaken;
    } PredInfo_t;

    typedef struct packed {
        logic      taken;
        PredInfo_t info;
    } BranchUpdate_t;

endpackage

/* rtl/BranchPredictionTable.sv */
`timescale 1ns/10ps

module BranchPredictionTable #(
    parameter int SIZE = 64
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     readValid,
    input  logic [$clog2(SIZE)-1:0]  readAddr,
    output logic                     taken,
    input  logic                     writeEn,
    input  logic [$clog2(SIZE)-1:0]  writeAddr,
    input  logic                     writeInit,
    input  logic                     writeTaken,
    output logic                     ready
);
    localparam int AW = $clog2(SIZE);

    logic [1:0] ctr [SIZE];
    logic [AW:0] sweepIdx;  // top bit set once every entry has been initialized

    assign ready = sweepIdx[AW];

    always_ff @(posedge clk) begin
        if (readValid) begin
            taken <= ctr[readAddr][1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sweepIdx <= '0;
        end else if (!sweepIdx[AW]) begin
            ctr[sweepIdx[AW-1:0]] <= 2'b01;  // weakly not taken
            sweepIdx <= sweepIdx + 1'b1;
        end else if (writeEn) begin
            if (writeInit) begin
                ctr[writeAddr] <= {writeTaken, !writeTaken};
            end else if (writeTaken && ctr[writeAddr] != 2'b11) begin
                ctr[writeAddr] <= ctr[writeAddr] + 2'b01;
            end else if (!writeTaken && ctr[writeAddr] != 2'b00) begin
                ctr[writeAddr] <= ctr[writeAddr] - 2'b01;
            end
        end
    end

endmodule

/* rtl/TageHistory.sv */
`timescale 1ns/10ps

module TageHistory import TagePkg::*, BranchPkg::*; #(
    parameter int SHORT_HIST = 4,
    parameter int LONG_HIST = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [PC_W-1:0]              reqPc,
    input  logic                         shiftValid,
    input  logic                         shiftTaken,
    output logic [IDX_W-1:0]             baseIdx,
    output TableProbe_t [NUM_TAGGED-1:0] probes
);
    logic [LONG_HIST-1:0] ghist;  // bit 0 is the most recent outcome
    logic [IDX_W-1:0] idxFold [NUM_TAGGED];
    logic [TAG_W-1:0] tagFold [NUM_TAGGED];
    logic [IDX_W-1:0] pcIdx;
    logic [TAG_W-1:0] pcTag;

    always_ff @(posedge clk) begin
        if (rst)
            ghist <= '0;
        else if (shiftValid)
            ghist <= {ghist[LONG_HIST-2:0], shiftTaken};
    end

    // fold each table's slice of history down to index and tag width
    always_comb begin
        for (int t = 0; t < NUM_TAGGED; t++) begin
            idxFold[t] = '0;
            tagFold[t] = '0;
            for (int i = 0; i < LONG_HIST; i++) begin
                if (i < ((t == 0) ? SHORT_HIST : LONG_HIST)) begin
                    idxFold[t][i % IDX_W] ^= ghist[i];
                    tagFold[t][TAG_W - 1 - (i % TAG_W)] ^= ghist[i];  // reversed, unlike the index
                end
            end
        end
    end

    assign pcIdx = reqPc[IDX_W+1:2];  // word aligned fetch
    assign pcTag = reqPc[TAG_W+1:2] ^ reqPc[2*TAG_W+1:TAG_W+2];
    assign baseIdx = pcIdx;

    always_comb begin
        for (int t = 0; t < NUM_TAGGED; t++) begin
            // upper half folded down again so small tables still see every history bit
            probes[t].idx = pcIdx ^ reqPc[2*IDX_W+1:IDX_W+2] ^ idxFold[t]
                ^ (idxFold[t] >> (IDX_W / 2));
            probes[t].tag = pcTag ^ tagFold[t];
        end
    end

endmodule

/* rtl/TageLookup.sv */
`timescale 1ns/10ps

module TageLookup import TagePkg::*, BranchPkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         reqValid,
    input  TableProbe_t [NUM_TAGGED-1:0] probes,
    input  logic [IDX_W-1:0]             baseIdx,
    input  logic                         baseTaken,
    input  logic [NUM_TAGGED-1:0]        hits,
    input  logic [NUM_TAGGED-1:0]        tableTaken,
    output logic                         predValid,
    output logic                         predTaken,
    output PredInfo_t                    predInfo
);
    logic validQ;
    logic [IDX_W-1:0] baseIdxQ;
    TableProbe_t [NUM_TAGGED-1:0] probesQ;
    logic [1:0] provider;
    logic altTaken;
    logic finalTaken;

    always_ff @(posedge clk) begin
        if (rst)
            validQ <= 1'b0;
        else
            validQ <= reqValid;
    end

    always_ff @(posedge clk) begin
        if (reqValid) begin
            baseIdxQ <= baseIdx;
            probesQ <= probes;
        end
    end

    // walk upward so the last hit provides and the one before it is the alternate
    always_comb begin
        provider = 2'd0;
        finalTaken = baseTaken;
        altTaken = baseTaken;
        for (int t = 0; t < NUM_TAGGED; t++) begin
            if (hits[t]) begin
                altTaken = finalTaken;
                finalTaken = tableTaken[t];
                provider = 2'(t + 1);
            end
        end
    end

    assign predValid = validQ;
    assign predTaken = finalTaken;

    always_comb begin
        predInfo.baseIdx = baseIdxQ;
        predInfo.probe = probesQ;
        predInfo.provider = provider;
        predInfo.altTaken = altTaken;
        predInfo.predTaken = finalTaken;
    end

endmodule

/* rtl/TagePkg.sv */
package TagePkg;

    localparam int TAG_W = 9;
    localparam int IDX_W = 8;       // tables use only the low log2(SIZE) bits
    localparam int NUM_TAGGED = 2;  // table 0 short history, table 1 long history

    // where a request lands in one tagged table and what it must match there
    typedef struct packed {
        logic [IDX_W-1:0] idx;
        logic [TAG_W-1:0] tag;
    } TableProbe_t;

endpackage

/* rtl/TagePredictor.sv */
`timescale 1ns/10ps

module TagePredictor import TagePkg::*, BranchPkg::*; #(
    parameter int SIZE = 64,
    parameter int SHORT_HIST = 4,
    parameter int LONG_HIST = 16,
    parameter int CLEAR_INTERVAL = 12
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            reqValid,
    input  logic [PC_W-1:0] reqPc,
    output logic            predValid,
    output logic            predTaken,
    output PredInfo_t       predInfo,
    input  logic            updValid,
    input  BranchUpdate_t   upd,
    output logic            ready
);
    localparam int AW = $clog2(SIZE);

    logic [IDX_W-1:0] baseIdx;
    TableProbe_t [NUM_TAGGED-1:0] probes;
    logic baseTaken;
    logic baseReady;
    logic [NUM_TAGGED-1:0] hits;
    logic [NUM_TAGGED-1:0] tableTaken;
    logic [NUM_TAGGED-1:0] tableReady;
    logic [NUM_TAGGED-1:0] allocAvail;
    logic baseWriteEn;
    logic [IDX_W-1:0] baseWriteAddr;
    logic [NUM_TAGGED-1:0] writeValid;
    TableProbe_t [NUM_TAGGED-1:0] writeProbe;
    logic [NUM_TAGGED-1:0] writeUpdate;
    logic [NUM_TAGGED-1:0] writeUseful;
    logic [NUM_TAGGED-1:0] writeCorrect;
    logic [NUM_TAGGED-1:0] doAlloc;
    logic [NUM_TAGGED-1:0] allocFailed;

    assign ready = baseReady && (&tableReady);

    TageHistory #(.SHORT_HIST(SHORT_HIST), .LONG_HIST(LONG_HIST)) i_history (
        .clk(clk), .rst(rst), .reqPc(reqPc),
        .shiftValid(updValid), .shiftTaken(upd.taken),  // history moves only on resolved branches
        .baseIdx(baseIdx), .probes(probes)
    );

    BranchPredictionTable #(.SIZE(SIZE)) i_base (
        .clk(clk), .rst(rst),
        .readValid(reqValid), .readAddr(baseIdx[AW-1:0]), .taken(baseTaken),
        .writeEn(baseWriteEn), .writeAddr(baseWriteAddr[AW-1:0]),
        .writeInit(1'b0), .writeTaken(upd.taken), .ready(baseReady)
    );

    for (genvar t = 0; t < NUM_TAGGED; t++) begin : g_tagged
        TageTable #(.SIZE(SIZE), .CLEAR_INTERVAL(CLEAR_INTERVAL)) i_table (
            .clk(clk), .rst(rst),
            .readValid(reqValid), .readProbe(probes[t]),
            .hit(hits[t]), .readTaken(tableTaken[t]),
            .writeValid(writeValid[t]), .writeProbe(writeProbe[t]), .writeTaken(upd.taken),
            .writeUpdate(writeUpdate[t]), .writeUseful(writeUseful[t]),
            .writeCorrect(writeCorrect[t]), .allocAvail(allocAvail[t]),
            .doAlloc(doAlloc[t]), .allocFailed(allocFailed[t]), .ready(tableReady[t])
        );
    end

    TageLookup i_lookup (
        .clk(clk), .rst(rst), .reqValid(reqValid), .probes(probes), .baseIdx(baseIdx),
        .baseTaken(baseTaken), .hits(hits), .tableTaken(tableTaken),
        .predValid(predValid), .predTaken(predTaken), .predInfo(predInfo)
    );

    TageUpdate i_update (
        .updValid(updValid), .upd(upd), .allocAvail(allocAvail),
        .baseWriteEn(baseWriteEn), .baseWriteAddr(baseWriteAddr),
        .writeValid(writeValid), .writeProbe(writeProbe), .writeUpdate(writeUpdate),
        .writeUseful(writeUseful), .writeCorrect(writeCorrect),
        .doAlloc(doAlloc), .allocFailed(allocFailed)
    );

endmodule

/* rtl/TageTable.sv */
`timescale 1ns/10ps

module TageTable import TagePkg::*; #(
    parameter int SIZE = 64,
    parameter int CLEAR_INTERVAL = 12
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        readValid,
    input  TableProbe_t readProbe,
    output logic        hit,
    output logic        readTaken,
    input  logic        writeValid,
    input  TableProbe_t writeProbe,
    input  logic        writeTaken,
    input  logic        writeUpdate,
    input  logic        writeUseful,
    input  logic        writeCorrect,
    output logic        allocAvail,
    input  logic        doAlloc,
    input  logic        allocFailed,
    output logic        ready
);
    localparam int AW = $clog2(SIZE);

    logic [TAG_W-1:0] tags [SIZE];
    logic [1:0] useful [SIZE];
    logic [TAG_W-1:0] storedTag;
    logic [TAG_W-1:0] probeTag;
    logic [AW-1:0] wa;
    logic [AW:0] sweepIdx;
    logic [CLEAR_INTERVAL-1:0] clearCnt;
    logic clearBit;  // which usefulness bit the next clear hits
    logic ctrReady;

    assign wa = writeProbe.idx[AW-1:0];
    assign allocAvail = useful[wa] == 2'b00;
    assign hit = storedTag == probeTag;  // compared the cycle after the read
    assign ready = sweepIdx[AW] && ctrReady;

    BranchPredictionTable #(.SIZE(SIZE)) counters (
        .clk        (clk),
        .rst        (rst),
        .readValid  (readValid),
        .readAddr   (readProbe.idx[AW-1:0]),
        .taken      (readTaken),
        .writeEn    (writeValid && (writeUpdate || (doAlloc && allocAvail))),
        .writeAddr  (wa),
        .writeInit  (!writeUpdate),  // a fresh allocation starts weak
        .writeTaken (writeTaken),
        .ready      (ctrReady)
    );

    always_ff @(posedge clk) begin
        if (readValid) begin
            storedTag <= tags[readProbe.idx[AW-1:0]];
            probeTag <= readProbe.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sweepIdx <= '0;
            clearCnt <= '0;
            clearBit <= 1'b0;
        end else begin
            if (!sweepIdx[AW]) begin
                tags[sweepIdx[AW-1:0]] <= '0;
                useful[sweepIdx[AW-1:0]] <= 2'b00;
                sweepIdx <= sweepIdx + 1'b1;
            end else if (writeValid) begin
                if (writeUpdate) begin
                    if (writeUseful) begin  // saturating in both directions
                        if (writeCorrect && useful[wa] != 2'b11)
                            useful[wa] <= useful[wa] + 2'b01;
                        else if (!writeCorrect && useful[wa] != 2'b00)
                            useful[wa] <= useful[wa] - 2'b01;
                    end
                end else if (doAlloc) begin
                    if (allocAvail)
                        tags[wa] <= writeProbe.tag;
                end else if (allocFailed && !allocAvail) begin
                    useful[wa] <= useful[wa] - 2'b01;
                end
            end

            // aging of usefulness, low and high bit in turn
            if (clearCnt == '0) begin
                for (int i = 0; i < SIZE; i++)
                    useful[i][clearBit] <= 1'b0;
                clearBit <= !clearBit;
            end
            clearCnt <= clearCnt - 1'b1;
        end
    end

endmodule

/* rtl/TageUpdate.sv */
`timescale 1ns/10ps

module TageUpdate import TagePkg::*, BranchPkg::*; (
    input  logic                         updValid,
    input  BranchUpdate_t                upd,
    input  logic [NUM_TAGGED-1:0]        allocAvail,
    output logic                         baseWriteEn,
    output logic [IDX_W-1:0]             baseWriteAddr,
    output logic [NUM_TAGGED-1:0]        writeValid,
    output TableProbe_t [NUM_TAGGED-1:0] writeProbe,
    output logic [NUM_TAGGED-1:0]        writeUpdate,
    output logic [NUM_TAGGED-1:0]        writeUseful,
    output logic [NUM_TAGGED-1:0]        writeCorrect,
    output logic [NUM_TAGGED-1:0]        doAlloc,
    output logic [NUM_TAGGED-1:0]        allocFailed
);
    logic mispred;
    logic allocFound;
    logic [NUM_TAGGED-1:0] isProvider;
    logic [NUM_TAGGED-1:0] aboveProvider;

    assign mispred = upd.taken != upd.info.predTaken;
    assign baseWriteEn = updValid && upd.info.provider == 2'd0;
    assign baseWriteAddr = upd.info.baseIdx;
    assign writeProbe = upd.info.probe;

    always_comb begin
        for (int t = 0; t < NUM_TAGGED; t++) begin
            isProvider[t] = upd.info.provider == 2'(t + 1);
            aboveProvider[t] = int'(upd.info.provider) <= t;
            writeUpdate[t] = isProvider[t];
            // only worth scoring when the alternate would have said something else
            writeUseful[t] = isProvider[t] && upd.info.altTaken != upd.info.predTaken;
            writeCorrect[t] = !mispred;
        end
    end

    // first free table above the provider takes the new entry
    always_comb begin
        allocFound = 1'b0;
        doAlloc = '0;
        for (int t = 0; t < NUM_TAGGED; t++) begin
            if (mispred && aboveProvider[t] && allocAvail[t] && !allocFound) begin
                doAlloc[t] = 1'b1;
                allocFound = 1'b1;
            end
        end
    end

    assign allocFailed = (mispred && !allocFound) ? aboveProvider : '0;

    always_comb begin
        for (int t = 0; t < NUM_TAGGED; t++)
            writeValid[t] = updValid && (isProvider[t] || doAlloc[t] || allocFailed[t]);
    end

endmodule

/* sim/TagePredictor_tb.sv */
`timescale 1ns/10ps

module TagePredictor_tb import BranchPkg::*; ();
    localparam int SIZE = 64;
    localparam int PERIOD = 8;
    localparam int ITERATIONS = 420;  // predictions requested over all tests, with some margin
    localparam int TIMEOUT = (ITERATIONS * 6 + SIZE + 40) * PERIOD;

    logic clk = 1'b0;
    logic rst;
    logic reqValid;
    logic [PC_W-1:0] reqPc;
    logic predValid;
    logic predTaken;
    PredInfo_t predInfo;
    logic updValid;
    BranchUpdate_t upd;
    logic ready;

    integer seed = 32'h62b9_ff28;
    int errors = 0;
    int checks = 0;
    logic lastTaken;
    PredInfo_t lastInfo;

    TagePredictor i_TagePredictor (
        .clk(clk), .rst(rst), .reqValid(reqValid), .reqPc(reqPc),
        .predValid(predValid), .predTaken(predTaken), .predInfo(predInfo),
        .updValid(updValid), .upd(upd), .ready(ready)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // issues one request alone and expects its answer exactly one cycle later
    task automatic requestPrediction(input logic [PC_W-1:0] pc);
        @(posedge clk);
        reqValid <= 1'b1;
        reqPc <= pc;
        @(negedge clk);
        checkValue("predValid", predValid, 1'b0);
        @(posedge clk);
        reqValid <= 1'b0;
        @(negedge clk);
        checkValue("predValid", predValid, 1'b1);
        lastTaken = predTaken;
        lastInfo = predInfo;
        @(negedge clk);
        checkValue("predValid", predValid, 1'b0);
    endtask

    task automatic sendUpdate(input logic taken, input PredInfo_t info);
        @(posedge clk);
        updValid <= 1'b1;
        upd.taken <= taken;
        upd.info <= info;
        @(posedge clk);
        updValid <= 1'b0;
    endtask

    task automatic runBranch(input logic [PC_W-1:0] pc, input logic taken);
        requestPrediction(pc);
        sendUpdate(taken, lastInfo);
    endtask

    task automatic resetAndInit();
        int cycles;
        logic [PC_W-1:0] pc;
        repeat (2) begin
            @(posedge clk);
            @(negedge clk);
            checkValue("predValid", predValid, 1'b0);
            checkValue("ready", ready, 1'b0);
        end
        @(posedge clk);
        rst <= 1'b0;
        cycles = 0;
        while (!ready && cycles < SIZE + 2) begin
            @(negedge clk);
            cycles++;
        end
        if (!ready) begin
            errors++;
            $display("ready did not rise within %0d cycles after reset", SIZE + 2);
        end
        // every counter starts weakly not taken
        for (int i = 0; i < 16; i++) begin
            pc = $random(seed);
            pc[1:0] = 2'b00;
            requestPrediction(pc);
            checkValue("predTaken", lastTaken, 1'b0);
        end
    endtask

    task automatic trainSingleBranch();
        logic [PC_W-1:0] pc;
        pc = 32'h0000_1040;
        requestPrediction(pc);
        checkValue("predTaken", lastTaken, 1'b0);
        sendUpdate(1'b1, lastInfo);
        requestPrediction(pc);
        checkValue("predTaken", lastTaken, 1'b1);  // base or a fresh weak entry
        sendUpdate(1'b0, lastInfo);
        runBranch(pc, 1'b0);
        requestPrediction(pc);
        checkValue("predTaken", lastTaken, 1'b0);
    endtask

    task automatic backToBackRequests();
        logic [PC_W-1:0] pcs [4];
        PredInfo_t infos [4];
        logic takens [4];
        pcs[0] = 32'h0000_1040;
        for (int i = 1; i < 4; i++) begin
            pcs[i] = $random(seed);
            pcs[i][1:0] = 2'b00;
        end
        // reference answers with one request in flight
        for (int i = 0; i < 4; i++) begin
            requestPrediction(pcs[i]);
            checkValue("predTaken", lastTaken, 1'b0);  // none of these is trained taken yet
            infos[i] = lastInfo;
            takens[i] = lastTaken;
        end
        @(posedge clk);
        reqValid <= 1'b1;
        reqPc <= pcs[0];
        for (int i = 1; i <= 4; i++) begin
            @(posedge clk);
            if (i < 4)
                reqPc <= pcs[i];
            else
                reqValid <= 1'b0;
            @(negedge clk);
            checkValue("predValid", predValid, 1'b1);
            checkValue("predInfo", predInfo, infos[i-1]);
            checkValue("predTaken", predTaken, takens[i-1]);
        end
        @(negedge clk);
        checkValue("predValid", predValid, 1'b0);
    endtask

    // the two history contexts need separate tagged entries
    task automatic alternatingPattern();
        logic outcome;
        for (int i = 0; i < 60; i++) begin
            outcome = (i % 2) == 0;
            requestPrediction(32'h0040_2a8c);
            if (i >= 50)
                checkValue("predTaken", lastTaken, outcome);
            sendUpdate(outcome, lastInfo);
        end
    endtask

    task automatic biasedRandomBranches();
        logic [PC_W-1:0] pcs [8];
        logic dirs [8];
        logic [31:0] rnd;
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            pcs[i] = (rnd & 32'hffff_ffe0) | (i << 2);  // distinct base entries
            rnd = $random(seed);
            dirs[i] = rnd[0];
        end
        for (int r = 0; r < 40; r++) begin
            for (int i = 0; i < 8; i++) begin
                requestPrediction(pcs[i]);
                if (r == 39)
                    checkValue("predTaken", lastTaken, dirs[i]);
                sendUpdate(dirs[i], lastInfo);
            end
        end
    endtask

    initial begin
        #(TIMEOUT);
        $display("timeout after %0d ns, the tests did not finish", TIMEOUT);
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        reqValid = 1'b0;
        reqPc = '0;
        updValid = 1'b0;
        upd = '0;
        resetAndInit();
        trainSingleBranch();
        backToBackRequests();
        alternatingPattern();
        biasedRandomBranches();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* vlog.f */
rtl/TagePkg.sv
rtl/BranchPkg.sv
rtl/BranchPredictionTable.sv
rtl/TageTable.sv
rtl/TageHistory.sv
rtl/TageLookup.sv
rtl/TageUpdate.sv
rtl/TagePredictor.sv
sim/TagePredictor_tb.sv
